//--- filelist.f
calc_pkg.sv
key_bus_if.sv
keypad_scanner.sv
key_fifo.sv
calc_engine.sv
calc_top.sv
calc_sva.sv
calc_checker.sv
tb_calc.sv

//--- run.sh
#!/bin/sh
# Build and run the keypad calculator testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_calc -f filelist.f -o sim_calc
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_calc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides pass or fail
if grep -qx "STATUS: PASS" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- calc_stimulus.txt
// P keys hold gap: press each key for hold cycles, release for gap
// B key hold gap: short bounce; E value: expected signed result
P 105* 30 24
E 105
P 2007* 30 24
E 2007
P 2A3C4* 30 24
E 20
P 300C300* 30 24
E 24464
P 256C128* 30 24
E -32768
P 5B9* 30 24
E -4
P 12DA5* 30 24
E -7
P 8* 30 24
E 8
P 9A9# 30 24
P 4A1* 30 24
E 5
P 7 200 24
P * 30 24
E 7
B 6 8 24
P 1 30 24
B 5 10 24
P 2* 30 24
E 12
P 3DC3D* 30 24
E 9

//--- tb_calc.sv
module tb_calc;
    timeunit 1ns;
    timeprecision 1ps;
    import calc_pkg::*;

    logic                     clk;
    logic                     nRST;
    logic [3:0]               row;
    logic [3:0]               col;
    logic signed [DATA_W-1:0] result;
    logic                     result_valid;

    logic         key_down;                               // Keypad model state
    logic [1:0]   key_col;
    logic [1:0]   key_row;
    byte          seq_kind [$];
    logic [127:0] seq_keys [$];                           // Up to 16 key characters
    int           seq_hold [$];
    int           seq_gap  [$];
    int           cycle_limit = 0;
    int           cycles      = 0;
    int           file_errors = 0;
    int           total;

    calc_top DUT (
        .clk          (clk),
        .nRST         (nRST),
        .row          (row),
        .col          (col),
        .result       (result),
        .result_valid (result_valid)
    );

    calc_checker u_check (
        .clk          (clk),
        .nRST         (nRST),
        .col          (col),
        .result       (result),
        .result_valid (result_valid)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Pressed key pulls its row low while its column is driven
    always_comb begin
        row = 4'hF;
        if (key_down && col[key_col] == 1'b0) begin
            row[key_row] = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles with results still outstanding", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Keypad layout, index is col*4 + row
    function automatic int key_index(input byte k);
        case (k)
            "1": return 0;
            "4": return 1;
            "7": return 2;
            "*": return 3;
            "2": return 4;
            "5": return 5;
            "8": return 6;
            "0": return 7;
            "3": return 8;
            "6": return 9;
            "9": return 10;
            "#": return 11;
            "A": return 12;
            "B": return 13;
            "C": return 14;
            "D": return 15;
            default: return -1;
        endcase
    endfunction

    function automatic int key_count(input logic [127:0] keys);
        int n;
        n = 0;
        for (int b = 0; b < 16; b++) begin
            if (keys[b*8 +: 8] != 8'h00) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic read_stimulus();
        int           fd;
        int           n;
        byte          kind;
        logic [959:0] rest;
        logic [127:0] keys;
        int           hold;
        int           gap;
        int           value;
        fd = $fopen("calc_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open calc_stimulus.txt");
            file_errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", kind);
            if (n != 1) begin
                break;
            end
            if (kind == "/") begin
                n = $fgets(rest, fd);                     // Comment line
            end else if (kind == "P" || kind == "B") begin
                keys = '0;
                n = $fscanf(fd, " %s %d %d", keys, hold, gap);
                if (n != 3) begin
                    $display("Stimulus file has a malformed '%c' line", kind);
                    file_errors++;
                end else begin
                    seq_kind.push_back(kind);
                    seq_keys.push_back(keys);
                    seq_hold.push_back(hold);
                    seq_gap.push_back(gap);
                    cycle_limit += key_count(keys) * (hold + gap);
                end
            end else if (kind == "E") begin
                n = $fscanf(fd, " %d", value);
                if (n != 1) begin
                    $display("Stimulus file has an expect line without a value");
                    file_errors++;
                end else begin
                    u_check.push_expect(value[DATA_W-1:0]);
                end
            end else begin
                $display("Stimulus file has an unknown line type '%c'", kind);
                file_errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic press_key(input byte k, input int hold, input int gap);
        int idx;
        idx = key_index(k);
        if (idx < 0) begin
            $display("Stimulus file names an unknown key '%c'", k);
            file_errors++;
        end else begin
            key_col  = idx[3:2];
            key_row  = idx[1:0];
            key_down = 1'b1;
        end
        repeat (hold) @(posedge clk);
        #1 key_down = 1'b0;
        repeat (gap) @(posedge clk);
        #1;
    endtask

    task automatic run_line(input byte kind, input logic [127:0] keys,
                            input int hold, input int gap);
        byte ch;
        if (kind == "B" && hold >= DEBOUNCE_CYCLES) begin
            $display("Bounce line holds a key for %0d cycles, long enough to count", hold);
            file_errors++;
        end
        for (int b = 15; b >= 0; b--) begin
            ch = keys[b*8 +: 8];
            if (ch != 8'h00) begin
                press_key(ch, hold, gap);
            end
        end
    endtask

    initial begin
        nRST     = 1'b0;
        key_down = 1'b0;
        key_col  = 2'd0;
        key_row  = 2'd0;
        read_stimulus();
        cycle_limit += 200;                               // Margin for reset and drain
        repeat (5) @(posedge clk);
        #1 nRST = 1'b1;
        foreach (seq_kind[i]) begin
            run_line(seq_kind[i], seq_keys[i], seq_hold[i], seq_gap[i]);
        end
        while (u_check.pending() > 0) begin
            @(posedge clk);
        end
        repeat (30) @(posedge clk);                       // Window for stray results
        u_check.report_unused();
        total = u_check.mismatches + u_check.extras + u_check.pending() + file_errors
                + DUT.u_fifo.u_sva.failures;
        $display("Errors: mismatches %0d, extras %0d, unused %0d, stimulus %0d, sva %0d",
                 u_check.mismatches, u_check.extras, u_check.pending(), file_errors,
                 DUT.u_fifo.u_sva.failures);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- calc_checker.sv
module calc_checker (
    input logic                                clk,
    input logic                                nRST,
    input logic [3:0]                          col,
    input logic signed [calc_pkg::DATA_W-1:0]  result,
    input logic                                result_valid
);
    timeunit 1ns;
    timeprecision 1ps;
    import calc_pkg::*;

    logic signed [DATA_W-1:0] expected [$];              // Filled from the stimulus file
    int                       mismatches = 0;
    int                       extras     = 0;

    task automatic push_expect(input logic signed [DATA_W-1:0] value);
        expected.push_back(value);
    endtask

    function automatic int pending();
        return expected.size();
    endfunction

    task automatic check_result(input logic signed [DATA_W-1:0] got);
        logic signed [DATA_W-1:0] want;
        if (expected.size() == 0) begin
            $display("Extra result %0d at %0t with no expected value left", got, $time);
            extras++;
        end else begin
            want = expected.pop_front();
            if (got !== want) begin
                $display("FAIL %0t: result %0d, expected %0d", $time, got, want);
                mismatches++;
            end
        end
    endtask

    task automatic report_unused();
        if (expected.size() != 0) begin
            $display("%0d expected results never arrived, next was %0d",
                     expected.size(), expected[0]);
        end
    endtask

    // Sample mid-cycle where the outputs are stable
    always @(negedge clk) begin
        if (!nRST) begin
            if (col !== 4'hF || result_valid !== 1'b0 || result !== '0) begin
                $display("FAIL %0t: reset values wrong, col %h result %0d valid %b",
                         $time, col, result, result_valid);
                mismatches++;
            end
        end else begin
            if ($isunknown(col) || $countones(~col) > 1) begin
                $display("FAIL %0t: col %b drives more than one column", $time, col);
                mismatches++;
            end
            if (result_valid === 1'b1) begin
                check_result(result);
            end else if (result_valid !== 1'b0) begin
                $display("FAIL %0t: result_valid is unknown", $time);
                mismatches++;
            end
        end
    end

endmodule

//--- calc_sva.sv
module calc_sva (
    input logic                       clk,
    input logic                       nRST,
    input logic                       wr_stb,
    input logic                       wr_ack,
    input logic                       rd_stb,
    input logic                       rd_ack,
    input logic [calc_pkg::FIFO_AW:0] count
);
    timeunit 1ns;
    timeprecision 1ps;
    import calc_pkg::*;

    int failures = 0;                                     // Read by the testbench top

    wr_stb_held: assert property (@(posedge clk) disable iff (!nRST)
        (wr_stb && !wr_ack) |=> wr_stb)
    else begin
        $error("Write stb dropped before ack");
        failures++;
    end

    rd_stb_held: assert property (@(posedge clk) disable iff (!nRST)
        (rd_stb && !rd_ack) |=> rd_stb)
    else begin
        $error("Read stb dropped before ack");
        failures++;
    end

    wr_ack_pulse: assert property (@(posedge clk) disable iff (!nRST)
        wr_ack |-> (wr_stb ##1 !wr_ack))
    else begin
        $error("Write ack without stb or longer than one cycle");
        failures++;
    end

    rd_ack_pulse: assert property (@(posedge clk) disable iff (!nRST)
        rd_ack |-> (rd_stb ##1 !rd_ack))
    else begin
        $error("Read ack without stb or longer than one cycle");
        failures++;
    end

    // A full FIFO never acks a write
    wr_ack_not_full: assert property (@(posedge clk) disable iff (!nRST)
        wr_ack |-> (count != (FIFO_AW + 1)'(FIFO_DEPTH)))
    else begin
        $error("Write ack while FIFO full");
        failures++;
    end

endmodule

bind key_fifo calc_sva u_sva (
    .clk    (clk),
    .nRST   (nRST),
    .wr_stb (wr.stb),
    .wr_ack (wr.ack),
    .rd_stb (rd.stb),
    .rd_ack (rd.ack),
    .count  (count)
);

//--- calc_top.sv
module calc_top (
    input  logic                                clk,
    input  logic                                nRST,
    input  logic [3:0]                          row,          // Keypad rows, active low
    output logic [3:0]                          col,          // Keypad columns, active low
    output logic signed [calc_pkg::DATA_W-1:0]  result,
    output logic                                result_valid
);

    key_bus_if wr_bus ();                                 // Scanner into FIFO
    key_bus_if rd_bus ();                                 // FIFO out to engine

    keypad_scanner u_scanner (
        .clk  (clk),
        .nRST (nRST),
        .row  (row),
        .col  (col),
        .bus  (wr_bus.master)
    );

    key_fifo u_fifo (
        .clk  (clk),
        .nRST (nRST),
        .wr   (wr_bus.slave),
        .rd   (rd_bus.slave)
    );

    calc_engine u_engine (
        .clk          (clk),
        .nRST         (nRST),
        .bus          (rd_bus.master),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

//--- calc_engine.sv
module calc_engine (
    input  logic                                clk,
    input  logic                                nRST,
    key_bus_if.master                           bus,
    output logic signed [calc_pkg::DATA_W-1:0]  result,
    output logic                                result_valid
);
    import calc_pkg::*;

    logic              req;
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] entry;                             // Number being typed
    logic [DATA_W-1:0] applied;                           // Pending op on acc and entry
    cmd_t              pend_op;                           // CMD_EQ means plain load
    key_event_t        ev;

    assign bus.cyc   = req;
    assign bus.stb   = req;
    assign bus.we    = 1'b0;                              // Read-only master
    assign bus.dat_w = '0;
    assign ev        = bus.dat_r;

    // All ops wrap modulo 2^16
    always_comb begin
        case (pend_op)
            CMD_ADD: applied = acc + entry;
            CMD_SUB: applied = acc - entry;
            CMD_MUL: applied = acc * entry;
            default: applied = entry;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            req          <= 1'b0;
            acc          <= '0;
            entry        <= '0;
            pend_op      <= CMD_EQ;
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (bus.ack) begin
                req <= 1'b0;
                if (ev.kind == KIND_DIGIT) begin
                    entry <= entry * DATA_W'(10) + DATA_W'(ev.payload.digit);
                end else begin
                    case (ev.payload.cmd)
                        CMD_NEG: entry <= -entry;
                        CMD_ADD, CMD_SUB, CMD_MUL: begin
                            acc     <= applied;           // Strict left to right
                            pend_op <= ev.payload.cmd;
                            entry   <= '0;
                        end
                        CMD_EQ: begin
                            result       <= applied;
                            result_valid <= 1'b1;
                            acc          <= '0;
                            entry        <= '0;
                            pend_op      <= CMD_EQ;
                        end
                        CMD_CLR: begin
                            acc     <= '0;                // Drop partial work
                            entry   <= '0;
                            pend_op <= CMD_EQ;
                        end
                        default: ;
                    endcase
                end
            end else if (!req) begin
                req <= 1'b1;                              // Idle, ask for next key
            end
        end
    end

endmodule

//--- key_fifo.sv
module key_fifo (
    input  logic      clk,
    input  logic      nRST,
    key_bus_if.slave  wr,
    key_bus_if.slave  rd
);
    import calc_pkg::*;

    key_event_t         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               empty;
    logic               wr_go;
    logic               rd_go;

    assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    // New request seen and it can be served
    assign wr_go = wr.cyc & wr.stb & wr.we & ~wr.ack & ~full;
    assign rd_go = rd.cyc & rd.stb & ~rd.we & ~rd.ack & ~empty;

    assign wr.dat_r = '0;                                 // Write port returns no data

    // Pointers and count move in the ack cycle
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            wr.ack <= 1'b0;
            rd.ack <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr.ack <= wr_go;
            rd.ack <= rd_go;
            if (wr.ack) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd.ack) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr.ack, rd.ack})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                                // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr.ack) begin
            mem[wr_ptr] <= wr.dat_w;                      // Master still holds data here
        end
        if (rd_go) begin
            rd.dat_r <= mem[rd_ptr];
        end
    end

endmodule

//--- keypad_scanner.sv
module keypad_scanner (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] row,                               // Active low
    output logic [3:0] col,                               // Active low, one at a time
    key_bus_if.master  bus
);
    import calc_pkg::*;

    logic [1:0]      state;
    logic [1:0]      col_idx;                             // Column now driven
    logic [1:0]      next_idx;
    logic [15:0]     key_matrix;                          // Snapshot taken at freeze
    logic [15:0]     live_matrix;                         // Current read of driven column
    logic [DB_W-1:0] db_cnt;
    logic            db_last;
    logic            any_row;
    logic            req;
    key_event_t      key_ev;

    assign next_idx    = col_idx + 2'd1;
    assign live_matrix = {12'b0, ~row} << {col_idx, 2'b00};
    assign any_row     = (row != 4'hF);
    assign db_last     = (db_cnt == DB_W'(DEBOUNCE_CYCLES - 1));

    assign bus.cyc = req;
    assign bus.stb = req;
    assign bus.we  = 1'b1;                                // Write-only master

    // Bit index is col*4 + row
    always_comb begin
        key_ev      = '0;
        key_ev.kind = (|key_matrix[15:12] | key_matrix[11] | key_matrix[3]) ?
                      KIND_CMD : KIND_DIGIT;
        case (key_matrix)
            16'h0001: key_ev.payload.digit = 4'd1;
            16'h0002: key_ev.payload.digit = 4'd4;
            16'h0004: key_ev.payload.digit = 4'd7;
            16'h0008: key_ev.payload.cmd   = CMD_EQ;      // '*'
            16'h0010: key_ev.payload.digit = 4'd2;
            16'h0020: key_ev.payload.digit = 4'd5;
            16'h0040: key_ev.payload.digit = 4'd8;
            16'h0080: key_ev.payload.digit = 4'd0;
            16'h0100: key_ev.payload.digit = 4'd3;
            16'h0200: key_ev.payload.digit = 4'd6;
            16'h0400: key_ev.payload.digit = 4'd9;
            16'h0800: key_ev.payload.cmd   = CMD_CLR;     // '#'
            16'h1000: key_ev.payload.cmd   = CMD_ADD;
            16'h2000: key_ev.payload.cmd   = CMD_SUB;
            16'h4000: key_ev.payload.cmd   = CMD_MUL;
            16'h8000: key_ev.payload.cmd   = CMD_NEG;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= ST_SCAN;
            col_idx    <= 2'd0;
            col        <= 4'hF;
            key_matrix <= '0;
            db_cnt     <= '0;
            req        <= 1'b0;
        end else begin
            case (state)
                ST_SCAN: begin
                    if (col != 4'hF && any_row) begin
                        key_matrix <= live_matrix;        // Freeze on this column
                        db_cnt     <= '0;
                        state      <= ST_PRESS;
                    end else begin
                        col_idx <= next_idx;
                        col     <= ~(4'b0001 << next_idx);
                    end
                end
                ST_PRESS: begin
                    if (live_matrix != key_matrix || !$onehot(key_matrix)) begin
                        db_cnt <= '0;                     // Bounce or two keys
                        state  <= ST_RELEASE;
                    end else if (db_last) begin
                        req   <= 1'b1;
                        state <= ST_SEND;
                    end else begin
                        db_cnt <= db_cnt + 1'b1;
                    end
                end
                ST_SEND: begin
                    if (bus.ack) begin
                        req    <= 1'b0;
                        db_cnt <= '0;
                        state  <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    if (any_row) begin
                        db_cnt <= '0;                     // Still held, restart count
                    end else if (db_last) begin
                        state <= ST_SCAN;
                    end else begin
                        db_cnt <= db_cnt + 1'b1;
                    end
                end
                default: state <= ST_SCAN;
            endcase
        end
    end

    // Event word tracks the snapshot, then stays put through ST_SEND
    always_ff @(posedge clk) begin
        if (state == ST_PRESS) begin
            bus.dat_w <= key_ev;
        end
    end

endmodule

//--- key_bus_if.sv
interface key_bus_if;
    import calc_pkg::*;

    logic       cyc;
    logic       stb;
    logic       we;
    logic       ack;                                      // Registered, one cycle wide
    key_event_t dat_w;
    key_event_t dat_r;                                    // Valid in the ack cycle

    modport master (
        output cyc,
        output stb,
        output we,
        output dat_w,
        input  ack,
        input  dat_r
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  dat_w,
        output ack,
        output dat_r
    );

endinterface

//--- calc_pkg.sv
package calc_pkg;

    localparam int DEBOUNCE_CYCLES = 16;                  // Stable cycles to accept a change
    localparam int DB_W            = $clog2(DEBOUNCE_CYCLES);
    localparam int FIFO_DEPTH      = 4;
    localparam int FIFO_AW         = 2;                   // Pointer width for FIFO_DEPTH
    localparam int DATA_W          = 16;                  // Calculator word

    // Scanner FSM states
    localparam logic [1:0] ST_SCAN    = 2'd0;
    localparam logic [1:0] ST_PRESS   = 2'd1;
    localparam logic [1:0] ST_SEND    = 2'd2;
    localparam logic [1:0] ST_RELEASE = 2'd3;

    typedef enum logic {
        KIND_DIGIT = 1'b0,
        KIND_CMD   = 1'b1
    } key_kind_t;

    typedef enum logic [3:0] {
        CMD_ADD = 4'h0,                                   // A
        CMD_SUB = 4'h1,                                   // B
        CMD_MUL = 4'h2,                                   // C
        CMD_NEG = 4'h3,                                   // D
        CMD_EQ  = 4'h4,                                   // '*'
        CMD_CLR = 4'h5                                    // '#'
    } cmd_t;

    // Payload meaning depends on the event kind
    typedef union packed {
        logic [3:0] digit;                                // 0 to 9
        cmd_t       cmd;
    } key_payload_u;

    typedef struct packed {
        key_kind_t    kind;
        key_payload_u payload;
    } key_event_t;

endpackage
